// File: design/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // Width of the payload word carried by every beat
    parameter int data_width = 32;

    // Width of the destination tag, which only travels along with the beat
    parameter int dest_width = 4;

    // Operation code carried in the user field of each beat
    typedef enum logic [1:0] {
        op_pass       = 2'd0,
        op_negate     = 2'd1,
        op_shift      = 2'd2,
        op_accumulate = 2'd3
    } stream_op_t;

    // One stream beat, 39 bits wide with the default widths
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [dest_width-1:0] dest;
        stream_op_t            op;
        logic                  last;
    } stream_beat_t;

endpackage

`default_nettype wire

// File: design/stream_skid_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module stream_skid_buffer #(
    parameter bit register_output = 1'b1,
    parameter int data_width      = stream_pkg::data_width,
    parameter int dest_width      = stream_pkg::dest_width
) (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import stream_pkg::*;

    logic in_xfer;
    logic out_stall;
    logic out_free;
    logic skidding;
    logic ready_after_reset;

    logic [data_width-1:0] skid_data;
    logic [dest_width-1:0] skid_dest;
    stream_op_t            skid_op;
    logic                  skid_last;
    stream_beat_t          skid_beat;

    assign in_xfer   = in_valid && in_ready;
    assign out_stall = out_valid && !out_ready;
    assign out_free  = !out_valid || out_ready;

    // A beat accepted while the output stalls has nowhere to go but the skid register
    always_ff @(posedge clock) begin
        if (!reset) begin
            skidding <= 1'b0;
        end else if (in_xfer && out_stall) begin
            skidding <= 1'b1;
        end else if (out_free) begin
            skidding <= 1'b0;
        end
    end

    // Ready comes up one edge after reset is released
    always_ff @(posedge clock) begin
        ready_after_reset <= reset;
    end

    assign in_ready = ready_after_reset && !skidding;

    // Skid storage only holds a beat that could not be passed on
    always_ff @(posedge clock) begin
        if (in_xfer && out_stall) begin
            skid_data <= in_beat.data;
            skid_dest <= in_beat.dest;
            skid_op   <= in_beat.op;
            skid_last <= in_beat.last;
        end
    end

    always_comb begin
        skid_beat.data = skid_data;
        skid_beat.dest = skid_dest;
        skid_beat.op   = skid_op;
        skid_beat.last = skid_last;
    end

    if (register_output) begin : g_registered_output

        // The output register refills only when it is empty or being drained
        always_ff @(posedge clock) begin
            if (!reset) begin
                out_valid <= 1'b0;
                out_beat  <= '0;
            end else if (out_free) begin
                if (skidding) begin
                    out_valid <= 1'b1;
                    out_beat  <= skid_beat;
                end else begin
                    out_valid <= in_xfer;
                    if (in_xfer) begin
                        out_beat <= in_beat;
                    end
                end
            end
        end

    end else begin : g_combinational_output

        // While skidding the stored beat goes first, otherwise the live input passes through
        assign out_valid = skidding || in_xfer;
        assign out_beat  = skidding ? skid_beat : in_beat;

    end

endmodule

`default_nettype wire

// File: design/stream_op_stage.sv
`timescale 1ns/1ns
`default_nettype none

module stream_op_stage #(
    parameter int data_width = stream_pkg::data_width,
    parameter int dest_width = stream_pkg::dest_width
) (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import stream_pkg::*;

    logic                  in_xfer;
    logic [data_width-1:0] in_data;
    logic [dest_width-1:0] in_dest;
    logic [data_width-1:0] running_sum;
    logic [data_width-1:0] sum_next;
    logic [data_width-1:0] result;

    // Accept a new beat whenever the output register is empty or drains this cycle
    assign in_ready = !out_valid || out_ready;
    assign in_xfer  = in_valid && in_ready;

    assign in_data = in_beat.data;
    assign in_dest = in_beat.dest;

    // Sum wraps modulo two to the data width
    assign sum_next = running_sum + in_data;

    always_comb begin
        case (in_beat.op)
            op_pass: begin
                result = in_data;
            end
            op_negate: begin
                result = -in_data;
            end
            op_shift: begin
                // Top bit falls off the end
                result = {in_data[data_width-2:0], 1'b0};
            end
            op_accumulate: begin
                result = sum_next;
            end
            default: begin
                result = in_data;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Only accumulate beats move the sum, and the end of a packet starts it over
    always_ff @(posedge clock) begin
        if (!reset) begin
            running_sum <= '0;
        end else if (in_xfer) begin
            if (in_beat.last) begin
                running_sum <= '0;
            end else if (in_beat.op == op_accumulate) begin
                running_sum <= sum_next;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_beat <= '0;
        end else if (in_xfer) begin
            out_beat.data <= result;
            out_beat.dest <= in_dest;
            out_beat.op   <= in_beat.op;
            out_beat.last <= in_beat.last;
        end
    end

endmodule

`default_nettype wire

// File: design/stream_pipeline_top.sv
`timescale 1ns/1ns
`default_nettype none

module stream_pipeline_top #(
    parameter int data_width = stream_pkg::data_width,
    parameter int dest_width = stream_pkg::dest_width
) (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import stream_pkg::*;

    stream_beat_t stage_in_beat;
    logic         stage_in_valid;
    logic         stage_in_ready;

    stream_beat_t stage_out_beat;
    logic         stage_out_valid;
    logic         stage_out_ready;

    // Input side registers its output so the upstream sees a clean register boundary
    stream_skid_buffer #(
        .register_output (1'b1),
        .data_width      (data_width),
        .dest_width      (dest_width)
    ) u_skid_in (
        .clock     (clock),
        .reset     (reset),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (stage_in_beat),
        .out_valid (stage_in_valid),
        .out_ready (stage_in_ready)
    );

    stream_op_stage #(
        .data_width (data_width),
        .dest_width (dest_width)
    ) u_op_stage (
        .clock     (clock),
        .reset     (reset),
        .in_beat   (stage_in_beat),
        .in_valid  (stage_in_valid),
        .in_ready  (stage_in_ready),
        .out_beat  (stage_out_beat),
        .out_valid (stage_out_valid),
        .out_ready (stage_out_ready)
    );

    // Output side is combinational and only breaks the ready path
    stream_skid_buffer #(
        .register_output (1'b0),
        .data_width      (data_width),
        .dest_width      (dest_width)
    ) u_skid_out (
        .clock     (clock),
        .reset     (reset),
        .in_beat   (stage_out_beat),
        .in_valid  (stage_out_valid),
        .in_ready  (stage_out_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: verif/stream_pipeline_checker.sv
`timescale 1ns/1ns
`default_nettype none

module stream_pipeline_checker (
    input logic                     clock,
    input logic                     reset,
    input logic                     in_valid,
    input stream_pkg::stream_beat_t out_beat,
    input logic                     out_valid,
    input logic                     out_ready
);

    // Number of failed assertions, read by the testbench at the end of the run
    int failure_count = 0;

    // Nothing may be offered on either side while reset is held
    assert property (@(posedge clock) !reset |-> (!in_valid && !out_valid))
        else begin
            failure_count++;
            $error("Valid was high on a top-level port during reset");
        end

    // A stalled output beat must not change
    assert property (@(posedge clock) disable iff (!reset)
        (out_valid && !out_ready) |=> $stable(out_beat))
        else begin
            failure_count++;
            $error("out_beat changed while out_valid was high and out_ready low");
        end

    // Once offered, a beat stays offered until it is taken
    assert property (@(posedge clock) disable iff (!reset)
        (out_valid && !out_ready) |=> out_valid)
        else begin
            failure_count++;
            $error("out_valid dropped before the beat was transferred");
        end

endmodule

bind stream_pipeline_top stream_pipeline_checker u_checker (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

// File: verif/stream_pipeline_tb.sv
`timescale 1ns/1ns
`default_nettype none

module stream_pipeline_tb;
    import stream_pkg::*;

    localparam int drive_delay      = 1;
    localparam int reset_cycles     = 16;
    localparam int cycle_margin     = 200;
    localparam int single_beats     = 12;
    localparam int accumulate_beats = 60;
    localparam int stall_beats      = 120;
    localparam int mixed_beats      = 400;
    localparam int total_beats      = single_beats + accumulate_beats + stall_beats + mixed_beats;
    localparam int stall_one_in     = 4;
    localparam int gap_one_in       = 4;
    localparam int drain_cycles     = 16;

    // Kinds of packet the stimulus generator builds
    localparam int single_mode     = 0;
    localparam int accumulate_mode = 1;
    localparam int random_mode     = 2;

    logic         clock;
    logic         reset;
    stream_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;
    stream_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;

    stream_beat_t          pending[$];
    stream_beat_t          expected[$];
    stream_beat_t          wanted_beat;
    logic [31:0]           rng_state;
    logic [data_width-1:0] model_sum;
    logic                  in_taken;
    logic                  driving;
    logic                  stall_enable;
    logic                  gap_enable;
    int                    error_count;
    int                    assertion_failures;
    int                    accepted_count;
    int                    received_count;
    int                    cycle_count;
    int                    cycle_limit;

    stream_pipeline_top #(
        .data_width (data_width),
        .dest_width (dest_width)
    ) DUT (
        .clock     (clock),
        .reset     (reset),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic bit random_chance(input int one_in);
        return (next_random() % one_in) == 0;
    endfunction

    function automatic stream_op_t op_from_bits(input logic [1:0] bits);
        return stream_op_t'(bits);
    endfunction

    // Expected output beat for an input beat, given the packet's sum before it
    function automatic stream_beat_t predict_beat(input stream_beat_t beat,
                                                  input logic [data_width-1:0] sum);
        stream_beat_t result;
        result = beat;
        case (beat.op)
            op_pass:       result.data = beat.data;
            op_negate:     result.data = ~beat.data + data_width'(1);
            op_shift:      result.data = beat.data << 1;
            op_accumulate: result.data = sum + beat.data;
            default:       result.data = beat.data;
        endcase
        return result;
    endfunction

    function automatic logic [data_width-1:0] predict_sum(input stream_beat_t beat,
                                                          input logic [data_width-1:0] sum);
        if (beat.last) begin
            return '0;
        end
        if (beat.op == op_accumulate) begin
            return sum + beat.data;
        end
        return sum;
    endfunction

    task automatic compare_field(input string name, input logic [63:0] actual,
                                 input logic [63:0] wanted);
        if (actual !== wanted) begin
            error_count++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, actual, wanted, $time);
        end
    endtask

    // Builds beat_count beats of packets and appends them to the send queue
    task automatic queue_packets(input int beat_count, input int mode);
        stream_beat_t beat;
        logic [31:0]  draw;
        int           remaining_in_packet;
        remaining_in_packet = 0;
        for (int i = 0; i < beat_count; i++) begin
            if (remaining_in_packet == 0) begin
                if (mode == single_mode) begin
                    remaining_in_packet = 1;
                end else begin
                    remaining_in_packet = 1 + int'(next_random() % 8);
                end
            end
            draw = next_random();
            beat.data = data_width'(next_random());
            beat.dest = dest_width'(next_random());
            if (mode == single_mode) begin
                beat.op = op_from_bits(2'(i % 3));
            end else if (mode == accumulate_mode) begin
                beat.op = (draw[3:2] == 2'b00) ? op_from_bits(draw[1:0]) : op_accumulate;
                // Large values make the running sum wrap
                if (draw[4]) begin
                    beat.data[data_width-1 -: 4] = 4'hf;
                end
            end else begin
                beat.op = op_from_bits(draw[1:0]);
            end
            remaining_in_packet = remaining_in_packet - 1;
            if (i == beat_count - 1) begin
                remaining_in_packet = 0;
            end
            beat.last = (remaining_in_packet == 0);
            pending.push_back(beat);
        end
    endtask

    // Sends one group of packets and waits until the DUT has taken every beat
    task automatic run_phase(input int beat_count, input int mode,
                             input logic stalls, input logic gaps);
        stall_enable = stalls;
        gap_enable   = gaps;
        queue_packets(beat_count, mode);
        do begin
            @(posedge clock);
        end while (pending.size() > 0 || in_valid);
    endtask

    // Lets the last beats out, then keeps watching for a beat that should not exist
    task automatic drain_pipeline();
        int waited;
        stall_enable = 1'b0;
        gap_enable   = 1'b0;
        waited       = 0;
        while (expected.size() > 0 && waited < drain_cycles) begin
            @(posedge clock);
            waited++;
        end
        repeat (drain_cycles) @(posedge clock);
    endtask

    // Input and output handshakes, applied just after each rising edge
    always @(posedge clock) begin
        #drive_delay;
        if (driving) begin
            if (!in_valid || in_taken) begin
                if (pending.size() > 0 && !(gap_enable && random_chance(gap_one_in))) begin
                    in_beat  = pending.pop_front();
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = !(stall_enable && random_chance(stall_one_in));
        end
    end

    // Ready and valid depend only on registers, so mid-cycle values hold at the next edge
    always @(negedge clock) begin
        if (!reset) begin
            compare_field("in_ready", 64'(in_ready), 64'(0));
            compare_field("out_valid", 64'(out_valid), 64'(0));
            in_taken = 1'b0;
        end else begin
            in_taken = in_valid && in_ready;
            if (in_taken) begin
                expected.push_back(predict_beat(in_beat, model_sum));
                model_sum = predict_sum(in_beat, model_sum);
                accepted_count++;
            end
            if (out_valid && out_ready) begin
                received_count++;
                if (expected.size() == 0) begin
                    error_count++;
                    $display("An output beat with data 0x%0h came out with no beat in flight",
                             out_beat.data);
                end else begin
                    wanted_beat = expected.pop_front();
                    compare_field("out_beat.data", 64'(out_beat.data), 64'(wanted_beat.data));
                    compare_field("out_beat.dest", 64'(out_beat.dest), 64'(wanted_beat.dest));
                    compare_field("out_beat.op", 64'(out_beat.op), 64'(wanted_beat.op));
                    compare_field("out_beat.last", 64'(out_beat.last), 64'(wanted_beat.last));
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        reset          = 1'b0;
        in_beat        = '0;
        in_valid       = 1'b0;
        out_ready      = 1'b0;
        in_taken       = 1'b0;
        driving        = 1'b0;
        stall_enable   = 1'b0;
        gap_enable     = 1'b0;
        rng_state      = 32'd74;
        model_sum      = '0;
        error_count    = 0;
        accepted_count = 0;
        received_count = 0;
        cycle_count    = 0;
        cycle_limit    = 2 * total_beats + cycle_margin;

        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        reset = 1'b1;
        @(negedge clock);
        // Ready is registered from reset and lags its release by one cycle
        compare_field("in_ready", 64'(in_ready), 64'(0));
        @(posedge clock);
        driving = 1'b1;
        repeat (8) @(posedge clock);

        run_phase(single_beats, single_mode, 1'b0, 1'b0);
        run_phase(accumulate_beats, accumulate_mode, 1'b0, 1'b0);
        run_phase(stall_beats, random_mode, 1'b1, 1'b0);
        run_phase(mixed_beats, random_mode, 1'b1, 1'b1);
        drain_pipeline();

        if (expected.size() != 0) begin
            error_count++;
            $display("%0d expected beats never came out of the pipeline", expected.size());
        end
        compare_field("received_count", 64'(received_count), 64'(total_beats));

        assertion_failures = DUT.u_checker.failure_count;
        $display("Run complete: %0d beats sent, %0d received, %0d errors, %0d assertion failures",
                 accepted_count, received_count, error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
design/stream_pkg.sv
design/stream_skid_buffer.sv
design/stream_op_stage.sv
design/stream_pipeline_top.sv
verif/stream_pipeline_checker.sv
verif/stream_pipeline_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the stream pipeline testbench with Verilator, runs it and checks the log
set -eo pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
sim_name=stream_pipeline_sim
log_file=sim.log

verilator --binary --timing --assert \
    --top-module stream_pipeline_tb \
    -Mdir "$build_dir" -o "$sim_name" \
    -f compile.f

# Keep running past assertion errors so the testbench can give its own verdict
"./$build_dir/$sim_name" +verilator+error+limit+1000 | tee "$log_file"

if grep -qx "TEST FAILED" "$log_file"; then
    echo "Simulation reported a failure, see $log_file"
    exit 1
fi

echo "Simulation finished without a reported failure"
